// ==== files.f ====
+incdir+hw
hw/oooAluPkg.sv
hw/hostRegs.sv
hw/renameFile.sv
hw/aluResStation.sv
hw/aluExec.sv
hw/oooAluTop.sv
test/oooAluTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module oooAluTb -o oooAluSim

./obj_dir/oooAluSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    exit 1
fi

// ==== test/oooAluTb.sv ====
`timescale 1ns/100ps
`include "oooAlu_macros.svh"

module oooAluTb;
    import oooAluPkg::*;

    // reads, writes and status polls over all six tests
    localparam int transferCount = 309;
    localparam int cycleLimit = 20 * transferCount + 200;

    logic                        clk;
    logic                        reset;
    logic                        wbCyc;
    logic                        wbStb;
    logic                        wbWe;
    logic [`OOO_WB_ADDR_W-1:0]   wbAdr;
    logic [`OOO_WB_DATA_W-1:0]   wbDatW;
    logic [`OOO_WB_DATA_W-1:0]   wbDatR;
    logic                        wbAck;

    logic [`OOO_DATA_W-1:0] shadow [`OOO_REG_N];
    logic [31:0]            rngState;
    int                     cycles;

    oooAluTop u_dut (
        .clk(clk), .reset(reset),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic instWord_t makeReg(input aluOp_t op, input logic [2:0] rd,
                                          input logic [2:0] rs1, input logic [2:0] rs2);
        instWord_t w;
        w = '0;
        w.regForm.opField.op = op;
        w.regForm.rd = rd;
        w.regForm.rs1 = rs1;
        w.regForm.rs2 = rs2;
        return w;
    endfunction

    function automatic instWord_t makeImm(input aluOp_t op, input logic [2:0] rd,
                                          input logic [2:0] rs1, input logic [15:0] imm);
        instWord_t w;
        w = '0;
        w.immForm.opField.imm = 1'b1;
        w.immForm.opField.op = op;
        w.immForm.rd = rd;
        w.immForm.rs1 = rs1;
        w.immForm.imm = imm;
        return w;
    endfunction

    // in-order result of one instruction against the shadow registers
    function automatic logic [`OOO_DATA_W-1:0] refExec(input instWord_t w);
        logic [`OOO_DATA_W-1:0] a;
        logic [`OOO_DATA_W-1:0] b;
        a = shadow[w.regForm.rs1];
        b = w.regForm.opField.imm ? w.immForm.imm : shadow[w.regForm.rs2];
        case (w.regForm.opField.op)
            ADD: return a + b;
            SUB: return a - b;
            AND: return a & b;
            OR:  return a | b;
            XOR: return a ^ b;
            SLL: return a << b[3:0];
            SRL: return a >> b[3:0];
            default: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
        endcase
    endfunction

    task automatic checkData(input string name, input logic [`OOO_DATA_W-1:0] expVal,
                             input logic [`OOO_DATA_W-1:0] actVal);
        if (actVal !== expVal) begin
            $display("MISMATCH %s expected %h actual %h", name, expVal, actVal);
            $display("Testbench failed");
            $fatal(1, "data compare");
        end
    endtask

    task automatic checkMask(input string name, input logic [`OOO_RS_N-2:0] expMask,
                             input logic [`OOO_RS_N-2:0] actMask);
        if (actMask !== expMask) begin
            $display("MISMATCH %s expected %h actual %h", name, expMask, actMask);
            $display("Testbench failed");
            $fatal(1, "mask compare");
        end
    endtask

    // ack is registered, so look just after each edge
    task automatic waitAck();
        @(posedge clk);
        #1;
        while (!wbAck) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wbWrite(input logic [3:0] adr, input logic [31:0] data);
        @(posedge clk);
        #2;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b1;
        wbAdr = adr;
        wbDatW = data;
        waitAck();
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbRead(input logic [3:0] adr, output logic [31:0] data);
        @(posedge clk);
        #2;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = 1'b0;
        wbAdr = adr;
        waitAck();
        data = wbDatR;
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    task automatic sendInst(input instWord_t w);
        shadow[w.regForm.rd] = refExec(w);
        wbWrite(`OOO_ADDR_INST, w);
    endtask

    task automatic readCheck(input string name, input logic [2:0] idx);
        logic [31:0] data;
        wbRead(`OOO_ADDR_REG0 + 4'(idx), data);
        checkData($sformatf("%s r%0d", name, idx), shadow[idx], data[`OOO_DATA_W-1:0]);
    endtask

    task automatic readMask(output logic [`OOO_RS_N-2:0] mask);
        logic [31:0] data;
        wbRead(`OOO_ADDR_STATUS, data);
        mask = data[`OOO_RS_N-2:0];
    endtask

    initial begin
        logic [`OOO_RS_N-2:0] mask;
        clk = 1'b0;
        reset = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        cycles = 0;
        rngState = 32'd20;
        for (int i = 0; i < `OOO_REG_N; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // reset state
        for (int i = 0; i < `OOO_REG_N; i++) begin
            readCheck("reset", 3'(i));
        end
        readMask(mask);
        checkMask("resetMask", '1, mask);

        // r0 loaded last so the others still see zero in rs1
        for (int i = 1; i <= `OOO_REG_N; i++) begin
            sendInst(makeImm(ADD, 3'(i), 3'd0, 16'(16'h9e37 * i)));
        end
        for (int i = 0; i < `OOO_REG_N; i++) begin
            readCheck("load", 3'(i));
        end
        for (int k = 0; k < 8; k++) begin
            aluOp_t op;
            op = aluOp_t'(k);
            sendInst(makeReg(op, 3'(k + 1), 3'(k + 2), 3'(k + 5)));
            readCheck($sformatf("reg %s", op.name()), 3'(k + 1));
            sendInst(makeImm(op, 3'(k + 3), 3'(k), 16'(16'h3c5b * (k + 1))));
            readCheck($sformatf("imm %s", op.name()), 3'(k + 3));
        end

        // dependent chain read right behind its last write
        sendInst(makeImm(ADD, 3'd1, 3'd1, 16'h0013));
        sendInst(makeReg(SUB, 3'd2, 3'd1, 3'd3));
        sendInst(makeImm(SLL, 3'd3, 3'd2, 16'h0003));
        sendInst(makeReg(XOR, 3'd4, 3'd3, 3'd2));
        sendInst(makeImm(SRL, 3'd5, 3'd4, 16'h0002));
        sendInst(makeReg(ADD, 3'd6, 3'd5, 3'd4));
        readCheck("rawChain", 3'd6);

        // three producers for r5 and one consumer
        sendInst(makeReg(SUB, 3'd5, 3'd1, 3'd2));
        sendInst(makeImm(OR, 3'd5, 3'd3, 16'h00f0));
        sendInst(makeImm(SLL, 3'd5, 3'd4, 16'h0001));
        sendInst(makeReg(ADD, 3'd6, 3'd5, 3'd1));
        readCheck("wawConsumer", 3'd6);
        readCheck("wawFinal", 3'd5);

        // long chain on r7 fills the station
        for (int k = 0; k < 20; k++) begin
            sendInst(makeImm((k % 2 == 0) ? ADD : XOR, 3'd7, 3'd7, 16'(k * 37 + 5)));
        end
        for (int s = 0; s < 2; s++) begin
            readMask(mask);
            if (mask == '1) begin
                $display("status showed every slot free while the chain was still pending");
                $display("Testbench failed");
                $fatal(1, "drain check");
            end
        end
        for (int i = 0; i < `OOO_REG_N; i++) begin
            readCheck("drain", 3'(i));
        end
        readMask(mask);
        checkMask("drainMask", '1, mask);

        // random program
        for (int n = 0; n < 200; n++) begin
            rngState = xorshift(rngState);
            if (rngState[0]) begin
                sendInst(makeImm(aluOp_t'(rngState[3:1]), rngState[6:4], rngState[9:7],
                                 rngState[31:16]));
            end else begin
                sendInst(makeReg(aluOp_t'(rngState[3:1]), rngState[6:4], rngState[9:7],
                                 rngState[12:10]));
            end
        end
        for (int i = 0; i < `OOO_REG_N; i++) begin
            readCheck("random", 3'(i));
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== hw/oooAluTop.sv ====
`timescale 1ns/100ps
`include "oooAlu_macros.svh"

module oooAluTop (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wbCyc,
    input  logic                        wbStb,
    input  logic                        wbWe,
    input  logic [`OOO_WB_ADDR_W-1:0]   wbAdr,
    input  logic [`OOO_WB_DATA_W-1:0]   wbDatW,
    output logic [`OOO_WB_DATA_W-1:0]   wbDatR,
    output logic                        wbAck
);
    import oooAluPkg::*;

    instReq_t               instReq;
    logic                   instTaken;
    dispatch_t              dispatch;
    logic [`OOO_RS_N-2:0]   freeMask;
    issue_t                 issue;
    cdb_t                   cdb;
    logic [`OOO_REG_W-1:0]  readIdx;
    logic [`OOO_DATA_W-1:0] readValue;
    logic                   readPending;

    hostRegs u_hostRegs (
        .clk(clk), .reset(reset),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .instReq(instReq), .instTaken(instTaken),
        .readIdx(readIdx), .readValue(readValue), .readPending(readPending),
        .freeMask(freeMask)
    );

    renameFile u_renameFile (
        .clk(clk), .reset(reset),
        .instReq(instReq), .instTaken(instTaken), .freeMask(freeMask),
        .dispatch(dispatch), .cdb(cdb),
        .readIdx(readIdx), .readValue(readValue), .readPending(readPending)
    );

    aluResStation u_aluResStation (
        .clk(clk), .reset(reset),
        .dispatch(dispatch), .cdb(cdb), .issue(issue), .freeMask(freeMask)
    );

    aluExec u_aluExec (
        .clk(clk), .reset(reset), .issue(issue), .cdb(cdb)
    );

endmodule

// ==== hw/aluExec.sv ====
`timescale 1ns/100ps
`include "oooAlu_macros.svh"

module aluExec (
    input  logic                clk,
    input  logic                reset,
    input  oooAluPkg::issue_t   issue,
    output oooAluPkg::cdb_t     cdb
);
    import oooAluPkg::*;

    logic [`OOO_DATA_W-1:0] result;
    logic                   less;

    assign less = $signed(issue.a) < $signed(issue.b);

    always_comb begin
        result = '0;
        case (issue.op)
            ADD: result = issue.a + issue.b;
            SUB: result = issue.a - issue.b;
            AND: result = issue.a & issue.b;
            OR:  result = issue.a | issue.b;
            XOR: result = issue.a ^ issue.b;
            // shift amount from the low 4 bits only
            SLL: result = issue.a << issue.b[3:0];
            SRL: result = issue.a >> issue.b[3:0];
            SLT: result = {{(`OOO_DATA_W - 1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    // one broadcast per issued op, back to back
    always_ff @(posedge clk) begin
        cdb.tag <= issue.tag;
        cdb.data <= result;
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
        end
    end

endmodule

// ==== hw/aluResStation.sv ====
`timescale 1ns/100ps
`include "oooAlu_macros.svh"

module aluResStation (
    input  logic                    clk,
    input  logic                    reset,
    input  oooAluPkg::dispatch_t    dispatch,
    input  oooAluPkg::cdb_t         cdb,
    output oooAluPkg::issue_t       issue,
    output logic [`OOO_RS_N-2:0]    freeMask
);
    import oooAluPkg::*;

    // slot 0 is never used, tag 0 means no producer
    logic [`OOO_RS_N-1:0]   busy;
    aluOp_t                 slotOp [`OOO_RS_N];
    logic [`OOO_DATA_W-1:0] slotA [`OOO_RS_N];
    logic [`OOO_DATA_W-1:0] slotB [`OOO_RS_N];
    logic [`OOO_TAG_W-1:0]  slotTagA [`OOO_RS_N];
    logic [`OOO_TAG_W-1:0]  slotTagB [`OOO_RS_N];

    logic [`OOO_RS_N-1:0]   ready;
    logic [`OOO_RS_N-1:0]   pick;
    logic [`OOO_TAG_W-1:0]  pickTag;

    always_comb begin
        ready = '0;
        for (int i = 1; i < `OOO_RS_N; i++) begin
            ready[i] = busy[i] && slotTagA[i] == '0 && slotTagB[i] == '0;
        end
    end

    // lowest ready slot wins
    assign pick = ready & -ready;

    always_comb begin
        pickTag = '0;
        for (int i = 1; i < `OOO_RS_N; i++) begin
            if (pick[i]) begin
                pickTag = `OOO_TAG_W'(i);
            end
        end
    end

    // a tag stays reserved until its result has left the CDB
    always_comb begin
        freeMask = ~busy[`OOO_RS_N-1:1];
        if (issue.valid) begin
            freeMask[issue.tag - 1'b1] = 1'b0;
        end
        if (cdb.valid) begin
            freeMask[cdb.tag - 1'b1] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (|ready) begin
                busy[pickTag] <= 1'b0;
            end
            if (dispatch.valid) begin
                busy[dispatch.slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 1; i < `OOO_RS_N; i++) begin
            if (dispatch.valid && dispatch.slot == `OOO_TAG_W'(i)) begin
                slotOp[i] <= dispatch.op;
                slotA[i] <= dispatch.valueA;
                slotTagA[i] <= dispatch.tagA;
                slotB[i] <= dispatch.valueB;
                slotTagB[i] <= dispatch.tagB;
            end else if (cdb.valid && busy[i]) begin
                // snoop for operands still in flight
                if (slotTagA[i] == cdb.tag) begin
                    slotA[i] <= cdb.data;
                    slotTagA[i] <= '0;
                end
                if (slotTagB[i] == cdb.tag) begin
                    slotB[i] <= cdb.data;
                    slotTagB[i] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        issue.tag <= pickTag;
        issue.op <= slotOp[pickTag];
        issue.a <= slotA[pickTag];
        issue.b <= slotB[pickTag];
        if (reset) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= |ready;
        end
    end

endmodule

// ==== hw/renameFile.sv ====
`timescale 1ns/100ps
`include "oooAlu_macros.svh"

module renameFile (
    input  logic                    clk,
    input  logic                    reset,
    input  oooAluPkg::instReq_t     instReq,
    output logic                    instTaken,
    input  logic [`OOO_RS_N-2:0]    freeMask,
    output oooAluPkg::dispatch_t    dispatch,
    input  oooAluPkg::cdb_t         cdb,
    input  logic [`OOO_REG_W-1:0]   readIdx,
    output logic [`OOO_DATA_W-1:0]  readValue,
    output logic                    readPending
);
    import oooAluPkg::*;

    logic [`OOO_DATA_W-1:0] regValue [`OOO_REG_N];
    logic [`OOO_TAG_W-1:0]  regTag [`OOO_REG_N];

    instWord_t             word;
    logic                  isImm;
    logic [`OOO_REG_W-1:0] rd;
    logic [`OOO_REG_W-1:0] rs1;
    logic [`OOO_REG_W-1:0] rs2;
    logic [`OOO_TAG_W-1:0] newTag;

    assign word = instReq.word;
    assign isImm = word.regForm.opField.imm;
    // rd and rs1 sit at the same place in both forms
    assign rd = word.regForm.rd;
    assign rs1 = word.regForm.rs1;
    assign rs2 = word.regForm.rs2;

    // lowest free slot, bit 0 of the mask is slot 1
    always_comb begin
        newTag = '0;
        for (int i = `OOO_RS_N - 1; i >= 1; i--) begin
            if (freeMask[i-1]) begin
                newTag = `OOO_TAG_W'(i);
            end
        end
    end

    assign instTaken = instReq.valid && (newTag != '0);

    always_comb begin
        dispatch.valid = instTaken;
        dispatch.slot = newTag;
        dispatch.op = word.regForm.opField.op;
        dispatch.valueA = regValue[rs1];
        dispatch.tagA = regTag[rs1];
        dispatch.valueB = regValue[rs2];
        dispatch.tagB = regTag[rs2];
        // result broadcast this cycle would be missed by the slot
        if (cdb.valid && dispatch.tagA != '0 && dispatch.tagA == cdb.tag) begin
            dispatch.valueA = cdb.data;
            dispatch.tagA = '0;
        end
        if (isImm) begin
            dispatch.valueB = word.immForm.imm;
            dispatch.tagB = '0;
        end else if (cdb.valid && dispatch.tagB != '0 && dispatch.tagB == cdb.tag) begin
            dispatch.valueB = cdb.data;
            dispatch.tagB = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OOO_REG_N; i++) begin
                regValue[i] <= '0;
                regTag[i] <= '0;
            end
        end else begin
            // only the newest producer may retire the register
            for (int i = 0; i < `OOO_REG_N; i++) begin
                if (cdb.valid && regTag[i] != '0 && regTag[i] == cdb.tag) begin
                    regValue[i] <= cdb.data;
                    regTag[i] <= '0;
                end
            end
            if (instTaken) begin
                regTag[rd] <= newTag;
            end
        end
    end

    assign readValue = regValue[readIdx];
    assign readPending = regTag[readIdx] != '0;

endmodule

// ==== hw/hostRegs.sv ====
`timescale 1ns/100ps
`include "oooAlu_macros.svh"

module hostRegs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wbCyc,
    input  logic                        wbStb,
    input  logic                        wbWe,
    input  logic [`OOO_WB_ADDR_W-1:0]   wbAdr,
    input  logic [`OOO_WB_DATA_W-1:0]   wbDatW,
    output logic [`OOO_WB_DATA_W-1:0]   wbDatR,
    output logic                        wbAck,
    output oooAluPkg::instReq_t         instReq,
    input  logic                        instTaken,
    output logic [`OOO_REG_W-1:0]       readIdx,
    input  logic [`OOO_DATA_W-1:0]      readValue,
    input  logic                        readPending,
    input  logic [`OOO_RS_N-2:0]        freeMask
);

    logic active;
    logic isInst;
    logic isStatus;
    logic isReg;

    // ack of the previous cycle closes the transfer
    assign active = wbCyc && wbStb && !wbAck;

    assign isInst = wbAdr == `OOO_ADDR_INST;
    assign isStatus = wbAdr == `OOO_ADDR_STATUS;
    assign isReg = wbAdr >= `OOO_ADDR_REG0;

    assign instReq.valid = active && wbWe && isInst;
    assign instReq.word = wbDatW;

    // register block is aligned, low bits give the index
    assign readIdx = wbAdr[`OOO_REG_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
        end else if (active) begin
            if (wbWe) begin
                // held off while every slot is taken
                wbAck <= isInst ? instTaken : 1'b1;
            end else begin
                wbAck <= isReg ? !readPending : 1'b1;
            end
        end else begin
            wbAck <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (active && !wbWe) begin
            wbDatR <= '0;
            if (isStatus) begin
                wbDatR[`OOO_RS_N-2:0] <= freeMask;
            end else if (isReg) begin
                wbDatR[`OOO_DATA_W-1:0] <= readValue;
            end
        end
    end

endmodule

// ==== hw/oooAluPkg.sv ====
`include "oooAlu_macros.svh"

package oooAluPkg;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLL, SRL, SLT} aluOp_t;

    // top bit of the opcode field selects the immediate form
    typedef struct packed {
        logic   imm;
        aluOp_t op;
    } opField_t;

    typedef struct packed {
        opField_t                opField;
        logic [`OOO_REG_W-1:0]   rd;
        logic [`OOO_REG_W-1:0]   rs1;
        logic [`OOO_REG_W-1:0]   rs2;
        logic [18:0]             unused;
    } regForm_t;

    typedef struct packed {
        opField_t                opField;
        logic [`OOO_REG_W-1:0]   rd;
        logic [`OOO_REG_W-1:0]   rs1;
        logic [`OOO_DATA_W-1:0]  imm;
        logic [5:0]              unused;
    } immForm_t;

    typedef union packed {
        regForm_t regForm;
        immForm_t immForm;
    } instWord_t;

    typedef struct packed {
        logic      valid;
        instWord_t word;
    } instReq_t;

    // slot number doubles as the destination tag
    typedef struct packed {
        logic                   valid;
        logic [`OOO_TAG_W-1:0]  slot;
        aluOp_t                 op;
        logic [`OOO_DATA_W-1:0] valueA;
        logic [`OOO_TAG_W-1:0]  tagA;
        logic [`OOO_DATA_W-1:0] valueB;
        logic [`OOO_TAG_W-1:0]  tagB;
    } dispatch_t;

    typedef struct packed {
        logic                   valid;
        logic [`OOO_TAG_W-1:0]  tag;
        aluOp_t                 op;
        logic [`OOO_DATA_W-1:0] a;
        logic [`OOO_DATA_W-1:0] b;
    } issue_t;

    typedef struct packed {
        logic                   valid;
        logic [`OOO_TAG_W-1:0]  tag;
        logic [`OOO_DATA_W-1:0] data;
    } cdb_t;

endpackage

// ==== hw/oooAlu_macros.svh ====
`ifndef OOO_ALU_MACROS_SVH
`define OOO_ALU_MACROS_SVH

// datapath
`define OOO_DATA_W 16

// architectural registers
`define OOO_REG_N 8
`define OOO_REG_W 3

// reservation station, tag 0 marks a free or ready operand
`define OOO_RS_N 8
`define OOO_TAG_W 3

// wishbone port
`define OOO_WB_ADDR_W 4
`define OOO_WB_DATA_W 32

// word address map, registers at 8..15
`define OOO_ADDR_INST 4'd0
`define OOO_ADDR_STATUS 4'd1
`define OOO_ADDR_REG0 4'd8

`endif
